// ==== list.f ====
source/board_glue_pkg.sv
source/reset_monitor.sv
source/gpio_in_sync.sv
source/gpio_ctl_regs.sv
source/pad_iobuf.sv
source/board_top.sv
test/tb_clock_gen.sv
test/board_top_tb.sv

// ==== Makefile ====
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       ?= board_top_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation FAILED

.PHONY: sim clean

# The log decides the result; a crash without a message also fails
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/board_top_tb.sv ====
// Board glue testbench

`timescale 1ns/1ns

module board_top_tb
  import board_glue_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int WRITE_ROUNDS    = 40;
  localparam int PAD_ROUNDS      = 12;
  localparam int WATCHDOG_CYCLES = 2000;

  logic                  pcie_clk;
  logic                  pcie_rst;
  reg_wr_t               wr_req;
  reg_rd_t               rd_req;
  logic [REG_WIDTH-1:0]  rd_data;
  logic                  rd_valid;
  logic                  enable;
  logic                  txnrx;
  logic                  reset_done;
  wire                   clksel_pad;
  wire                   resetb_pad;
  wire                   sync_pad;
  wire                   en_agc_pad;
  wire [CTL_WIDTH-1:0]   ctl_pad;
  wire [STATUS_WIDTH-1:0] status_pad;
  wire [PAD_WIDTH-1:0]   pads_seen;
  logic [PAD_WIDTH-1:0]  weak_val;
  logic [GPIO_WIDTH-1:0] model_out;
  logic [GPIO_WIDTH-1:0] model_tris;

  tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
    .pcie_clk_o (pcie_clk),
    .pcie_rst_o (pcie_rst)
  );

  board_top uut (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .reg_wr_i       (wr_req),
    .reg_rd_i       (rd_req),
    .rd_data_o      (rd_data),
    .rd_valid_o     (rd_valid),
    .enable_o       (enable),
    .txnrx_o        (txnrx),
    .reset_done_o   (reset_done),
    .gpio_clksel_io (clksel_pad),
    .gpio_resetb_io (resetb_pad),
    .gpio_sync_io   (sync_pad),
    .gpio_en_agc_io (en_agc_pad),
    .gpio_ctl_io    (ctl_pad),
    .gpio_status_io (status_pad)
  );

  // ************************************************************
  // Pad models
  // ************************************************************

  // Weak keepers stand in for the transceiver and lose to any driven pad
  assign (weak0, weak1) clksel_pad = weak_val[15];
  assign (weak0, weak1) resetb_pad = weak_val[14];
  assign (weak0, weak1) sync_pad   = weak_val[13];
  assign (weak0, weak1) en_agc_pad = weak_val[12];
  assign (weak0, weak1) ctl_pad    = weak_val[11:8];
  assign (weak0, weak1) status_pad = weak_val[7:0];

  assign pads_seen = {clksel_pad, resetb_pad, sync_pad, en_agc_pad, ctl_pad, status_pad};

  // Bank position of each pad in the order of pads_seen
  function automatic logic [5:0] pin_of(input int n);
    logic [5:0] pin;
    if (n < STATUS_WIDTH) begin
      pin = 6'(PIN_STATUS_LSB + n);
    end else if (n < STATUS_WIDTH + CTL_WIDTH) begin
      pin = 6'(PIN_CTL_LSB + n - STATUS_WIDTH);
    end else begin
      case (n)
        12:      pin = 6'(PIN_EN_AGC);
        13:      pin = 6'(PIN_SYNC);
        14:      pin = 6'(PIN_RESETB);
        default: pin = 6'(PIN_CLKSEL);
      endcase
    end
    return pin;
  endfunction

  function automatic logic [PAD_WIDTH-1:0] expected_pads();
    logic [PAD_WIDTH-1:0] pads;
    for (int n = 0; n < PAD_WIDTH; n++) begin
      pads[n] = model_tris[pin_of(n)] ? weak_val[n] : model_out[pin_of(n)];
    end
    return pads;
  endfunction

  function automatic logic [REG_WIDTH-1:0] reg_expect(input logic [ADDR_WIDTH-1:0] addr);
    logic [GPIO_WIDTH-1:0] in_bank;
    logic [PAD_WIDTH-1:0]  pads;
    logic [REG_WIDTH-1:0]  value;
    pads    = expected_pads();
    in_bank = '0;
    for (int n = 0; n < PAD_WIDTH; n++) begin
      in_bank[pin_of(n)] = pads[n];
    end
    in_bank[PIN_RESET_DONE] = 1'b1;
    case (addr)
      REG_OUT_LO: value = model_out[31:0];
      REG_OUT_HI: value = model_out[63:32];
      REG_TRI_LO: value = model_tris[31:0];
      REG_TRI_HI: value = model_tris[63:32];
      REG_IN_LO:  value = in_bank[31:0];
      REG_IN_HI:  value = in_bank[63:32];
      default:    value = '0;
    endcase
    return value;
  endfunction

  // ************************************************************
  // Checks and bus tasks
  // ************************************************************

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge pcie_clk);
    #1;
  endtask

  task automatic check_outputs();
    check_value("pads", 64'(pads_seen), 64'(expected_pads()));
    check_value("enable_o", 64'(enable), 64'(model_out[PIN_ENABLE]));
    check_value("txnrx_o", 64'(txnrx), 64'(model_out[PIN_TXNRX]));
  endtask

  task automatic apply_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [REG_WIDTH-1:0] data);
    case (addr)
      REG_OUT_LO: model_out[31:0]   = data;
      REG_OUT_HI: model_out[63:32]  = data;
      REG_TRI_LO: model_tris[31:0]  = data;
      REG_TRI_HI: model_tris[63:32] = data;
      default: ;
    endcase
  endtask

  task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [REG_WIDTH-1:0] data);
    wr_req.en   = 1'b1;
    wr_req.addr = addr;
    wr_req.data = data;
    next_cycle();
    wr_req.en = 1'b0;
    apply_write(addr, data);
    check_outputs();
  endtask

  // A write alongside the read must not show up in the read data
  task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, input logic wr_too,
                          input logic [REG_WIDTH-1:0] wr_data);
    logic [REG_WIDTH-1:0] exp;
    exp          = reg_expect(addr);
    rd_req.en    = 1'b1;
    rd_req.addr  = addr;
    wr_req.en    = wr_too;
    wr_req.addr  = addr;
    wr_req.data  = wr_data;
    next_cycle();
    rd_req.en = 1'b0;
    wr_req.en = 1'b0;
    if (wr_too) begin
      apply_write(addr, wr_data);
    end
    check_true(rd_valid, $sformatf("read of address %0d got no rd_valid_o pulse", addr));
    check_value("rd_data_o", 64'(rd_data), 64'(exp));
    next_cycle();
    check_true(!rd_valid, "rd_valid_o stayed high for more than one cycle");
  endtask

  // ************************************************************
  // Stimulus
  // ************************************************************

  initial begin
    void'($urandom(32'h24a4));
    wr_req     = '0;
    rd_req     = '0;
    weak_val   = 16'($urandom());
    model_out  = '0;
    model_tris = '1;
    @(negedge pcie_rst);

    // Released pads, idle outputs and the settle count
    // The weak value flips every cycle so each released pad is seen at both levels
    for (int k = 1; k <= RESET_SETTLE_CYCLES; k++) begin
      weak_val = ~weak_val;
      next_cycle();
      check_outputs();
      check_value("rd_valid_o", 64'(rd_valid), 64'd0);
      check_value("reset_done_o", 64'(reset_done), 64'(k == RESET_SETTLE_CYCLES));
    end
    read_reg(REG_IN_LO, 1'b0, '0);

    // Random drive and tristate patterns that hit every register first
    for (int i = 0; i < WRITE_ROUNDS; i++) begin
      if (i % 10 == 9) begin
        weak_val = 16'($urandom());
        next_cycle();
        check_outputs();
      end
      write_reg((i < 4) ? 3'(i) : 3'($urandom_range(3, 0)), 32'($urandom()));
    end

    // Readback of every address once the pads have settled
    repeat (3) next_cycle();
    for (int a = 0; a < 8; a++) begin
      read_reg(3'(a), 1'b0, '0);
    end
    write_reg(REG_IN_LO, 32'($urandom()));
    write_reg(REG_IN_HI, 32'($urandom()));
    repeat (3) next_cycle();
    for (int a = 0; a < 6; a++) begin
      read_reg(3'(a), 1'b0, '0);
    end
    read_reg(REG_OUT_LO, 1'b1, 32'($urandom()));
    read_reg(REG_OUT_LO, 1'b0, '0);

    // Weak pad values seen through the synchronizer
    for (int i = 0; i < PAD_ROUNDS; i++) begin
      weak_val = 16'($urandom());
      write_reg(REG_TRI_HI, 32'($urandom()));
      repeat (3) next_cycle();
      read_reg(REG_IN_HI, 1'b0, '0);
    end

    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int CLK_PERIOD   = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic pcie_clk_o,
  output logic pcie_rst_o
);

  initial begin
    pcie_clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) pcie_clk_o = ~pcie_clk_o;
  end

  // Reset is released one nanosecond after a rising edge
  initial begin
    pcie_rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge pcie_clk_o);
    #1;
    pcie_rst_o = 1'b0;
  end

endmodule

// ==== source/board_top.sv ====
// Radio board PL glue top

`timescale 1ns/1ns

module board_top
  import board_glue_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,

  input  reg_wr_t               reg_wr_i,
  input  reg_rd_t               reg_rd_i,
  output logic [REG_WIDTH-1:0]  rd_data_o,
  output logic                  rd_valid_o,

  output logic                  enable_o,
  output logic                  txnrx_o,
  output logic                  reset_done_o,

  inout  wire                   gpio_clksel_io,
  inout  wire                   gpio_resetb_io,
  inout  wire                   gpio_sync_io,
  inout  wire                   gpio_en_agc_io,
  inout  wire [CTL_WIDTH-1:0]   gpio_ctl_io,
  inout  wire [STATUS_WIDTH-1:0] gpio_status_io
);

  gpio_drive_t           gpio_drive;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic                  reset_done;
  logic [PAD_WIDTH-1:0]  pad_t;
  logic [PAD_WIDTH-1:0]  pad_i;
  logic [PAD_WIDTH-1:0]  pad_raw;

  // ************************************************************
  // Input side
  // ************************************************************

  reset_monitor i_reset_monitor (
    .pcie_clk     (pcie_clk),
    .pcie_rst     (pcie_rst),
    .reset_done_o (reset_done)
  );

  gpio_in_sync i_gpio_in_sync (
    .pcie_clk     (pcie_clk),
    .pcie_rst     (pcie_rst),
    .pad_raw_i    (pad_raw),
    .reset_done_i (reset_done),
    .gpio_in_o    (gpio_in)
  );

  // ************************************************************
  // Register bank
  // ************************************************************

  gpio_ctl_regs i_gpio_ctl_regs (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .reg_wr_i   (reg_wr_i),
    .reg_rd_i   (reg_rd_i),
    .gpio_in_i  (gpio_in),
    .drive_o    (gpio_drive),
    .rd_data_o  (rd_data_o),
    .rd_valid_o (rd_valid_o)
  );

  assign reset_done_o = reset_done;

  // Radio enable and direction come from fixed bank bits
  assign enable_o = gpio_drive.out[PIN_ENABLE];
  assign txnrx_o  = gpio_drive.out[PIN_TXNRX];

  // ************************************************************
  // Output side
  // ************************************************************

  assign pad_t = bank_to_pads(gpio_drive.tris);
  assign pad_i = bank_to_pads(gpio_drive.out);

  pad_iobuf #(.DATA_WIDTH(1)) i_iobuf_clksel (
    .dio_t_i  (pad_t[PAD_CLKSEL]),
    .dio_i_i  (pad_i[PAD_CLKSEL]),
    .dio_o_o  (pad_raw[PAD_CLKSEL]),
    .dio_p_io (gpio_clksel_io)
  );

  pad_iobuf #(.DATA_WIDTH(1)) i_iobuf_resetb (
    .dio_t_i  (pad_t[PAD_RESETB]),
    .dio_i_i  (pad_i[PAD_RESETB]),
    .dio_o_o  (pad_raw[PAD_RESETB]),
    .dio_p_io (gpio_resetb_io)
  );

  pad_iobuf #(.DATA_WIDTH(1)) i_iobuf_sync (
    .dio_t_i  (pad_t[PAD_SYNC]),
    .dio_i_i  (pad_i[PAD_SYNC]),
    .dio_o_o  (pad_raw[PAD_SYNC]),
    .dio_p_io (gpio_sync_io)
  );

  pad_iobuf #(.DATA_WIDTH(1)) i_iobuf_en_agc (
    .dio_t_i  (pad_t[PAD_EN_AGC]),
    .dio_i_i  (pad_i[PAD_EN_AGC]),
    .dio_o_o  (pad_raw[PAD_EN_AGC]),
    .dio_p_io (gpio_en_agc_io)
  );

  pad_iobuf #(.DATA_WIDTH(CTL_WIDTH)) i_iobuf_ctl (
    .dio_t_i  (pad_t[PAD_CTL_LSB +: CTL_WIDTH]),
    .dio_i_i  (pad_i[PAD_CTL_LSB +: CTL_WIDTH]),
    .dio_o_o  (pad_raw[PAD_CTL_LSB +: CTL_WIDTH]),
    .dio_p_io (gpio_ctl_io)
  );

  // Status pins are normally left released for the transceiver to drive
  pad_iobuf #(.DATA_WIDTH(STATUS_WIDTH)) i_iobuf_status (
    .dio_t_i  (pad_t[PAD_STATUS_LSB +: STATUS_WIDTH]),
    .dio_i_i  (pad_i[PAD_STATUS_LSB +: STATUS_WIDTH]),
    .dio_o_o  (pad_raw[PAD_STATUS_LSB +: STATUS_WIDTH]),
    .dio_p_io (gpio_status_io)
  );

endmodule

// ==== source/pad_iobuf.sv ====
// Bidirectional pad buffers

`timescale 1ns/1ns

module pad_iobuf
  import board_glue_pkg::*;
#(
  parameter int DATA_WIDTH = PAD_WIDTH
) (
  input  logic [DATA_WIDTH-1:0] dio_t_i,
  input  logic [DATA_WIDTH-1:0] dio_i_i,
  output logic [DATA_WIDTH-1:0] dio_o_o,
  inout  wire  [DATA_WIDTH-1:0] dio_p_io
);

  // Each pin has its own tristate driver and a set tri bit lets the pad float
  for (genvar n = 0; n < DATA_WIDTH; n++) begin : g_pad
    assign dio_p_io[n] = dio_t_i[n] ? 1'bz : dio_i_i[n];
  end

  // The sensed level includes our own drive when the pad is enabled
  assign dio_o_o = dio_p_io;

endmodule

// ==== source/gpio_ctl_regs.sv ====
// GPIO host register bank

`timescale 1ns/1ns

module gpio_ctl_regs
  import board_glue_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,
  input  reg_wr_t               reg_wr_i,
  input  reg_rd_t               reg_rd_i,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output gpio_drive_t           drive_o,
  output logic [REG_WIDTH-1:0]  rd_data_o,
  output logic                  rd_valid_o
);

  gpio_drive_t          drive_q;
  logic [REG_WIDTH-1:0] rd_mux;

  // ************************************************************
  // Write side
  // ************************************************************

  // Every pad comes out of reset released and driving zero
  always_ff @(posedge pcie_clk or posedge pcie_rst) begin
    if (pcie_rst) begin
      drive_q.out  <= '0;
      drive_q.tris <= '1;
    end else if (reg_wr_i.en) begin
      case (reg_wr_i.addr)
        REG_OUT_LO: drive_q.out[REG_WIDTH-1:0]           <= reg_wr_i.data;
        REG_OUT_HI: drive_q.out[GPIO_WIDTH-1:REG_WIDTH]  <= reg_wr_i.data;
        REG_TRI_LO: drive_q.tris[REG_WIDTH-1:0]          <= reg_wr_i.data;
        REG_TRI_HI: drive_q.tris[GPIO_WIDTH-1:REG_WIDTH] <= reg_wr_i.data;
        // Input halves are read only
        default: ;
      endcase
    end
  end

  assign drive_o = drive_q;

  // ************************************************************
  // Read side
  // ************************************************************

  always_comb begin
    case (reg_rd_i.addr)
      REG_OUT_LO: rd_mux = drive_q.out[REG_WIDTH-1:0];
      REG_OUT_HI: rd_mux = drive_q.out[GPIO_WIDTH-1:REG_WIDTH];
      REG_TRI_LO: rd_mux = drive_q.tris[REG_WIDTH-1:0];
      REG_TRI_HI: rd_mux = drive_q.tris[GPIO_WIDTH-1:REG_WIDTH];
      REG_IN_LO:  rd_mux = gpio_in_i[REG_WIDTH-1:0];
      REG_IN_HI:  rd_mux = gpio_in_i[GPIO_WIDTH-1:REG_WIDTH];
      default:    rd_mux = '0;
    endcase
  end

  // A read in the same cycle as a write sees the value before the write
  always_ff @(posedge pcie_clk) begin
    rd_data_o <= rd_mux;
  end

  always_ff @(posedge pcie_clk or posedge pcie_rst) begin
    if (pcie_rst) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= reg_rd_i.en;
    end
  end

  // The host sees exactly one valid cycle per request, one edge later
  rd_valid_timing_a: assert property (
    @(posedge pcie_clk) disable iff (pcie_rst)
    rd_valid_o == $past(reg_rd_i.en)
  ) else $error("read valid did not follow the read request by one cycle");

  // The host driver only knows the six defined registers
  wr_addr_range_a: assert property (
    @(posedge pcie_clk) disable iff (pcie_rst)
    reg_wr_i.en |-> (reg_wr_i.addr <= REG_IN_HI)
  ) else $error("host wrote to a register address above 5");

endmodule

// ==== source/gpio_in_sync.sv ====
// GPIO input synchronizer

`timescale 1ns/1ns

module gpio_in_sync
  import board_glue_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,
  input  logic [PAD_WIDTH-1:0]  pad_raw_i,
  input  logic                  reset_done_i,
  output logic [GPIO_WIDTH-1:0] gpio_in_o
);

  logic [PAD_WIDTH-1:0] pad_meta;
  logic [PAD_WIDTH-1:0] pad_sync;

  // The transceiver pins change with no relation to pcie_clk
  always_ff @(posedge pcie_clk or posedge pcie_rst) begin
    if (pcie_rst) begin
      pad_meta <= '0;
      pad_sync <= '0;
    end else begin
      pad_meta <= pad_raw_i;
      pad_sync <= pad_meta;
    end
  end

  // reset_done already lives in this domain and goes straight to bit 0
  always_comb begin
    gpio_in_o = pads_to_bank(pad_sync);
    gpio_in_o[PIN_RESET_DONE] = reset_done_i;
  end

endmodule

// ==== source/reset_monitor.sv ====
// PCIe reset settle monitor

`timescale 1ns/1ns

module reset_monitor
  import board_glue_pkg::*;
(
  input  logic pcie_clk,
  input  logic pcie_rst,
  output logic reset_done_o
);

  logic [SETTLE_CNT_WIDTH-1:0] settle_cnt;

  // Count edges after release until the last count raises reset_done
  always_ff @(posedge pcie_clk or posedge pcie_rst) begin
    if (pcie_rst) begin
      settle_cnt   <= '0;
      reset_done_o <= 1'b0;
    end else if (!reset_done_o) begin
      if (settle_cnt == SETTLE_CNT_WIDTH'(RESET_SETTLE_CYCLES - 1)) begin
        reset_done_o <= 1'b1;
      end else begin
        settle_cnt <= settle_cnt + SETTLE_CNT_WIDTH'(1);
      end
    end
  end

  // Once the domain is up, only a new reset may take reset_done away
  done_holds_a: assert property (
    @(posedge pcie_clk) disable iff (pcie_rst)
    reset_done_o |=> reset_done_o
  ) else $error("reset_done fell while pcie_rst was low");

endmodule

// ==== source/board_glue_pkg.sv ====
// Board glue shared definitions

package board_glue_pkg;

  // ************************************************************
  // Bank widths and pin layout
  // ************************************************************

  localparam int GPIO_WIDTH   = 64;
  localparam int PAD_WIDTH    = 16;
  localparam int REG_WIDTH    = 32;
  localparam int ADDR_WIDTH   = 3;
  localparam int CTL_WIDTH    = 4;
  localparam int STATUS_WIDTH = 8;

  // Pin positions in the 64-bit bank
  localparam int PIN_CLKSEL     = 51;
  localparam int PIN_TXNRX      = 48;
  localparam int PIN_ENABLE     = 47;
  localparam int PIN_RESETB     = 46;
  localparam int PIN_SYNC       = 45;
  localparam int PIN_EN_AGC     = 44;
  localparam int PIN_CTL_LSB    = 40;
  localparam int PIN_STATUS_LSB = 32;
  localparam int PIN_RESET_DONE = 0;

  // Positions of the same pins in the packed 16-bit pad vector
  localparam int PAD_CLKSEL     = 15;
  localparam int PAD_RESETB     = 14;
  localparam int PAD_SYNC       = 13;
  localparam int PAD_EN_AGC     = 12;
  localparam int PAD_CTL_LSB    = 8;
  localparam int PAD_STATUS_LSB = 0;

  localparam int RESET_SETTLE_CYCLES = 16;
  localparam int SETTLE_CNT_WIDTH    = $clog2(RESET_SETTLE_CYCLES);

  // ************************************************************
  // Host register map
  // ************************************************************

  localparam logic [ADDR_WIDTH-1:0] REG_OUT_LO = 3'd0;
  localparam logic [ADDR_WIDTH-1:0] REG_OUT_HI = 3'd1;
  localparam logic [ADDR_WIDTH-1:0] REG_TRI_LO = 3'd2;
  localparam logic [ADDR_WIDTH-1:0] REG_TRI_HI = 3'd3;
  localparam logic [ADDR_WIDTH-1:0] REG_IN_LO  = 3'd4;
  localparam logic [ADDR_WIDTH-1:0] REG_IN_HI  = 3'd5;

  // A set bit in tris releases the pad
  typedef struct packed {
    logic [GPIO_WIDTH-1:0] out;
    logic [GPIO_WIDTH-1:0] tris;
  } gpio_drive_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [REG_WIDTH-1:0]  data;
  } reg_wr_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
  } reg_rd_t;

  // Gathers the 16 pad bits out of a bank vector
  function automatic logic [PAD_WIDTH-1:0] bank_to_pads(input logic [GPIO_WIDTH-1:0] bank);
    logic [PAD_WIDTH-1:0] pads;
    pads[PAD_CLKSEL] = bank[PIN_CLKSEL];
    pads[PAD_RESETB] = bank[PIN_RESETB];
    pads[PAD_SYNC]   = bank[PIN_SYNC];
    pads[PAD_EN_AGC] = bank[PIN_EN_AGC];
    pads[PAD_CTL_LSB +: CTL_WIDTH]       = bank[PIN_CTL_LSB +: CTL_WIDTH];
    pads[PAD_STATUS_LSB +: STATUS_WIDTH] = bank[PIN_STATUS_LSB +: STATUS_WIDTH];
    return pads;
  endfunction

  // Scatters the pad bits back to their pin positions, zero elsewhere
  function automatic logic [GPIO_WIDTH-1:0] pads_to_bank(input logic [PAD_WIDTH-1:0] pads);
    logic [GPIO_WIDTH-1:0] bank;
    bank = '0;
    bank[PIN_CLKSEL] = pads[PAD_CLKSEL];
    bank[PIN_RESETB] = pads[PAD_RESETB];
    bank[PIN_SYNC]   = pads[PAD_SYNC];
    bank[PIN_EN_AGC] = pads[PAD_EN_AGC];
    bank[PIN_CTL_LSB +: CTL_WIDTH]       = pads[PAD_CTL_LSB +: CTL_WIDTH];
    bank[PIN_STATUS_LSB +: STATUS_WIDTH] = pads[PAD_STATUS_LSB +: STATUS_WIDTH];
    return bank;
  endfunction

endpackage
